// File: bpu.f
source/bpu_pkg.sv
source/bpu_table.sv
source/gshare.sv
source/btb.sv
source/bpu.sv
dv/bpu_chk.sv
dv/bpu_tb.sv

// File: dv/bpu_tb.sv
`timescale 1ns/10ps

module bpu_tb;

  import bpu_pkg::*;

  localparam int unsigned HLEN         = 4;
  localparam int unsigned BTB_BITS     = 4;
  localparam int unsigned TAG_BITS     = XLEN - BTB_BITS - OFFSET;
  localparam int          NUM_STEPS    = 80;
  localparam int          NUM_DIRECTED = 30;
  localparam int          ECHO_TIMEOUT = 20;

  // Step kinds in the stimulus table
  localparam logic [1:0] KIND_LOOKUP  = 2'd0;
  localparam logic [1:0] KIND_RESOLVE = 2'd1;
  localparam logic [1:0] KIND_FLUSH   = 2'd2;

  // One table row
  // Lookups only use res.pc
  typedef struct packed {
    logic [1:0]  kind;
    resolution_t res;
  } step_t;

  logic        clk_i;
  logic        reset_i;
  logic        flush_i;
  logic [XLEN-1:0] curr_pc_i;
  logic        res_valid_i;
  resolution_t res_i;
  prediction_t pred_o;

  // Reference model state
  logic [HLEN-1:0]     hist_m;
  sat_cnt_t            cnt_m [2**HLEN];
  logic                btb_valid_m [2**BTB_BITS];
  logic [TAG_BITS-1:0] btb_tag_m [2**BTB_BITS];
  logic [XLEN-1:0]     btb_tgt_m [2**BTB_BITS];

  step_t       steps [NUM_STEPS];
  logic [31:0] lfsr_q;
  int          errors;
  int          checks;
  int          assert_fails;
  logic        timed_out;
  int          step;

  bpu #(
    .HLEN     (HLEN),
    .BTB_BITS (BTB_BITS)
  ) u_bpu (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .curr_pc_i   (curr_pc_i),
    .res_valid_i (res_valid_i),
    .res_i       (res_i),
    .pred_o      (pred_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  // One step per bit
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  function automatic step_t lookup_step(input logic [XLEN-1:0] pc);
    step_t s;
    s        = '0;
    s.kind   = KIND_LOOKUP;
    s.res.pc = pc;
    return s;
  endfunction

  function automatic step_t resolve_step(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                                         input logic taken, input logic mispredict);
    step_t s;
    s                = '0;
    s.kind           = KIND_RESOLVE;
    s.res.pc         = pc;
    s.res.target     = tgt;
    s.res.taken      = taken;
    s.res.mispredict = mispredict;
    return s;
  endfunction

  function automatic step_t flush_step();
    step_t s;
    s      = '0;
    s.kind = KIND_FLUSH;
    return s;
  endfunction

  task automatic build_table();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] tgt;
    logic            taken;
    logic            mispredict;
    // Cold lookups after reset
    steps[0]  = lookup_step(32'h0000_0100);
    steps[1]  = lookup_step(32'h0000_0204);
    steps[2]  = lookup_step(32'h0000_03fc);
    // Insert, then a delete with a foreign tag at the same index
    steps[3]  = resolve_step(32'h0000_0100, 32'h0000_0800, 1'b1, 1'b1);
    steps[4]  = resolve_step(32'h0000_0500, 32'h0000_0000, 1'b0, 1'b1);
    // Train the counter until history settles at all ones
    for (int i = 5; i <= 10; i++) begin
      steps[i] = resolve_step(32'h0000_0100, 32'h0000_0800, 1'b1, 1'b0);
    end
    // Another PC lifts the counter read by the lookup after the delete
    steps[8]  = resolve_step(32'h0000_0124, 32'h0000_0a40, 1'b1, 1'b0);
    steps[11] = lookup_step(32'h0000_0100);
    steps[12] = lookup_step(32'h0000_0500);
    // Matching delete removes the entry
    steps[13] = resolve_step(32'h0000_0100, 32'h0000_0000, 1'b0, 1'b1);
    steps[14] = lookup_step(32'h0000_0100);
    // Counters survive the flush so the re-insert is taken at once
    steps[15] = flush_step();
    steps[16] = resolve_step(32'h0000_010c, 32'h0000_0900, 1'b1, 1'b1);
    steps[17] = lookup_step(32'h0000_010c);
    steps[18] = lookup_step(32'h0000_0100);
    // Same PC under several histories
    steps[19] = resolve_step(32'h0000_0200, 32'h0000_0000, 1'b0, 1'b0);
    steps[20] = lookup_step(32'h0000_010c);
    steps[21] = resolve_step(32'h0000_0200, 32'h0000_0a00, 1'b1, 1'b0);
    steps[22] = lookup_step(32'h0000_010c);
    steps[23] = resolve_step(32'h0000_010c, 32'h0000_0900, 1'b1, 1'b0);
    steps[24] = lookup_step(32'h0000_010c);
    steps[25] = flush_step();
    steps[26] = lookup_step(32'h0000_010c);
    steps[27] = resolve_step(32'h0000_010c, 32'h0000_0900, 1'b1, 1'b1);
    steps[28] = lookup_step(32'h0000_010c);
    steps[29] = lookup_step(32'h0000_03fc);
    // Random mix over four tags and all sixteen indices
    for (int i = NUM_DIRECTED; i < NUM_STEPS; i++) begin
      if (rand_bit()) begin
        pc         = 32'h0000_1000 | (rand_bits(6) << 2);
        tgt        = 32'h0000_4000 | (rand_bits(8) << 2);
        taken      = rand_bit();
        mispredict = rand_bit();
        steps[i]   = resolve_step(pc, tgt, taken, mispredict);
      end else begin
        pc       = 32'h0000_1000 | (rand_bits(6) << 2);
        steps[i] = lookup_step(pc);
      end
    end
  endtask

  // Reset also reloads the counters while a flush keeps them
  task automatic model_clear(input logic counters_too);
    hist_m = '0;
    for (int i = 0; i < 2**BTB_BITS; i++) begin
      btb_valid_m[i] = 1'b0;
    end
    if (counters_too) begin
      for (int i = 0; i < 2**HLEN; i++) begin
        cnt_m[i] = SAT_WNT;
      end
    end
  endtask

  task automatic model_resolve(input resolution_t r);
    logic [HLEN-1:0]     ci;
    logic [BTB_BITS-1:0] bi;
    ci = r.pc[HLEN+1:2] ^ hist_m;
    bi = r.pc[BTB_BITS+1:2];
    if (r.taken && cnt_m[ci] != 2'd3) begin
      cnt_m[ci] = cnt_m[ci] + 2'd1;
    end else if (!r.taken && cnt_m[ci] != 2'd0) begin
      cnt_m[ci] = cnt_m[ci] - 2'd1;
    end
    if (r.mispredict && r.taken) begin
      btb_valid_m[bi] = 1'b1;
      btb_tag_m[bi]   = r.pc[XLEN-1:BTB_BITS+2];
      btb_tgt_m[bi]   = {r.target[XLEN-1:2], 2'b00};
    end else if (r.mispredict && btb_tag_m[bi] == r.pc[XLEN-1:BTB_BITS+2]) begin
      btb_valid_m[bi] = 1'b0;
    end
    hist_m = {hist_m[HLEN-2:0], r.taken};
  endtask

  // Prediction is combinational and the echoed PC marks it settled
  task automatic wait_echo(input logic [XLEN-1:0] pc, output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < ECHO_TIMEOUT) begin
      @(negedge clk_i);
      ok = (pred_o.pc === pc);
      n++;
    end
    if (!ok) begin
      $display("timeout: the prediction never showed pc %h", pc);
    end
  endtask

  task automatic check_lookup(input logic [XLEN-1:0] pc);
    logic [HLEN-1:0]     ci;
    logic [BTB_BITS-1:0] bi;
    logic                exp_taken;
    logic                ok;
    ci        = pc[HLEN+1:2] ^ hist_m;
    bi        = pc[BTB_BITS+1:2];
    exp_taken = cnt_m[ci][1] && btb_valid_m[bi] && (btb_tag_m[bi] == pc[XLEN-1:BTB_BITS+2]);
    wait_echo(pc, ok);
    if (!ok) begin
      timed_out = 1'b1;
    end else begin
      checks++;
      assert (pred_o.taken === exp_taken) else begin
        errors++;
        $display("error: pred_o.taken = %h, expected %h, pc %h", pred_o.taken, exp_taken, pc);
      end
      // Target only matters on a taken guess
      if (exp_taken) begin
        checks++;
        assert (pred_o.target === btb_tgt_m[bi]) else begin
          errors++;
          $display("error: pred_o.target = %h, expected %h, pc %h", pred_o.target,
                   btb_tgt_m[bi], pc);
        end
      end
    end
  endtask

  initial begin
    errors       = 0;
    checks       = 0;
    assert_fails = 0;
    timed_out    = 1'b0;
    lfsr_q       = 32'h52f9ebcc;
    reset_i      = 1'b1;
    flush_i      = 1'b0;
    curr_pc_i    = '0;
    res_valid_i  = 1'b0;
    res_i        = '0;
    build_table();
    model_clear(1'b1);
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    step = 0;
    // One table row per cycle and strobes last a single cycle
    while (step < NUM_STEPS && !timed_out) begin
      @(posedge clk_i);
      res_valid_i <= 1'b0;
      flush_i     <= 1'b0;
      case (steps[step].kind)
        KIND_RESOLVE: begin
          res_valid_i <= 1'b1;
          res_i       <= steps[step].res;
          model_resolve(steps[step].res);
        end
        KIND_FLUSH: begin
          flush_i <= 1'b1;
          model_clear(1'b0);
        end
        default: begin
          curr_pc_i <= steps[step].res.pc;
          check_lookup(steps[step].res.pc);
        end
      endcase
      step++;
    end
    @(posedge clk_i);
    res_valid_i <= 1'b0;
    flush_i     <= 1'b0;
    @(negedge clk_i);
    // Concurrent properties of the bound checker
    assert_fails = u_bpu.u_bpu_chk.fail_cnt;
    $display("checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
             checks, errors, assert_fails, timed_out);
    if (errors == 0 && assert_fails == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: dv/bpu_chk.sv
`timescale 1ns/10ps

module bpu_chk (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      flush_i,
  input logic [bpu_pkg::XLEN-1:0]  curr_pc_i,
  input bpu_pkg::prediction_t      pred_o
);

  import bpu_pkg::*;

  // Running count of failed properties
  int fail_cnt = 0;

  // Prediction always names the PC being fetched
  pc_echo_a : assert property (@(posedge clk_i) pred_o.pc == curr_pc_i)
    else begin
      $error("pred_o.pc does not follow curr_pc_i");
      fail_cnt++;
    end

  // Target is a word address so the alignment bits stay clear
  target_align_a : assert property (@(posedge clk_i) pred_o.target[OFFSET-1:0] == '0)
    else begin
      $error("pred_o.target has alignment bits set");
      fail_cnt++;
    end

  // BTB is empty right after reset or flush so nothing is taken
  clear_not_taken_a : assert property (@(posedge clk_i) (reset_i || flush_i) |=> !pred_o.taken)
    else begin
      $error("pred_o.taken high in the cycle after reset or flush");
      fail_cnt++;
    end

endmodule

bind bpu bpu_chk u_bpu_chk (.*);

// File: source/bpu.sv
`timescale 1ns/10ps

module bpu #(
  parameter int unsigned HLEN     = 4,
  parameter int unsigned BTB_BITS = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      flush_i,
  // PC being fetched this cycle
  input  logic [bpu_pkg::XLEN-1:0]  curr_pc_i,
  // Resolution strobe from commit
  input  logic                      res_valid_i,
  input  bpu_pkg::resolution_t      res_i,
  // Same-cycle prediction
  output bpu_pkg::prediction_t      pred_o
);

  import bpu_pkg::*;

  logic                   gshare_taken;
  logic                   btb_hit;
  logic [XLEN-OFFSET-1:0] btb_target;
  logic                   btb_update;
  logic                   btb_del_entry;

  // BTB only changes when the guess was wrong
  assign btb_update    = res_valid_i & res_i.mispredict;
  // Wrong and actually not taken, drop the entry
  assign btb_del_entry = res_i.mispredict & ~res_i.taken;

  // Direction predictor
  gshare #(
    .HLEN (HLEN)
  ) u_gshare (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .curr_pc_i   (curr_pc_i),
    .res_valid_i (res_valid_i),
    .res_i       (res_i),
    .taken_o     (gshare_taken)
  );

  // Target predictor
  btb #(
    .BTB_BITS (BTB_BITS)
  ) u_btb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .curr_pc_i   (curr_pc_i),
    .valid_i     (btb_update),
    .del_entry_i (btb_del_entry),
    .res_i       (res_i),
    .hit_o       (btb_hit),
    .target_o    (btb_target)
  );

  // Taken needs both a direction and a known target
  always_comb begin
    pred_o.pc     = curr_pc_i;
    pred_o.taken  = gshare_taken & btb_hit;
    pred_o.target = {btb_target, {OFFSET{1'b0}}};
  end

endmodule

// File: source/btb.sv
`timescale 1ns/10ps

module btb #(
  parameter int unsigned BTB_BITS = 4
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      flush_i,
  // Fetch side lookup
  input  logic [bpu_pkg::XLEN-1:0]                  curr_pc_i,
  // Update strobe and delete qualifier
  input  logic                                      valid_i,
  input  logic                                      del_entry_i,
  input  bpu_pkg::resolution_t                      res_i,
  output logic                                      hit_o,
  output logic [bpu_pkg::XLEN-bpu_pkg::OFFSET-1:0]  target_o
);

  import bpu_pkg::*;

  // Tag is what remains above the index bits
  localparam int unsigned TAG_BITS = XLEN - BTB_BITS - OFFSET;

  // Full entry, target kept as a word address
  typedef struct packed {
    logic                   valid;
    logic [TAG_BITS-1:0]    tag;
    logic [XLEN-OFFSET-1:0] target;
  } btb_entry_t;

  // Valid and tag only, for the delete check
  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
  } btb_shadow_t;

  // PC split for lookup
  logic [BTB_BITS-1:0] curr_idx;
  logic [TAG_BITS-1:0] curr_tag;
  // PC split for the resolution
  logic [BTB_BITS-1:0] res_idx;
  logic [TAG_BITS-1:0] res_tag;

  btb_entry_t  curr_entry;
  btb_shadow_t res_shadow;
  btb_entry_t  wr_entry;
  btb_shadow_t wr_shadow;
  logic        del_match;
  logic        wr_en;

  assign curr_idx = curr_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign curr_tag = curr_pc_i[XLEN-1:BTB_BITS+OFFSET];
  assign res_idx  = res_i.pc[BTB_BITS+OFFSET-1:OFFSET];
  assign res_tag  = res_i.pc[XLEN-1:BTB_BITS+OFFSET];

  // Delete only evicts the branch it names
  assign del_match = res_shadow.valid && (res_shadow.tag == res_tag);

  // Insert always writes, delete writes only on a tag match
  assign wr_en = valid_i && (!del_entry_i || del_match);

  // New entry, or an invalid one when deleting
  always_comb begin
    if (del_entry_i) begin
      wr_entry = '0;
    end else begin
      wr_entry.valid  = 1'b1;
      wr_entry.tag    = res_tag;
      wr_entry.target = res_i.target[XLEN-1:OFFSET];
    end
  end

  assign wr_shadow.valid = wr_entry.valid;
  assign wr_shadow.tag   = wr_entry.tag;

  // Main entry array read by fetch
  // Flush drops every entry and beats a same-cycle write
  bpu_table #(
    .DEPTH_BITS (BTB_BITS),
    .entry_t    (btb_entry_t),
    .RESET_VAL  ('0)
  ) u_entries (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .clear_i   (flush_i),
    .rd_idx_i  (curr_idx),
    .rd_data_o (curr_entry),
    .wr_en_i   (wr_en),
    .wr_idx_i  (res_idx),
    .wr_data_i (wr_entry)
  );

  // Shadow valid and tag, read at the resolution index
  bpu_table #(
    .DEPTH_BITS (BTB_BITS),
    .entry_t    (btb_shadow_t),
    .RESET_VAL  ('0)
  ) u_shadow (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .clear_i   (flush_i),
    .rd_idx_i  (res_idx),
    .rd_data_o (res_shadow),
    .wr_en_i   (wr_en),
    .wr_idx_i  (res_idx),
    .wr_data_i (wr_shadow)
  );

  // Hit needs a live entry with the same tag
  assign hit_o    = curr_entry.valid && (curr_entry.tag == curr_tag);
  assign target_o = curr_entry.target;

endmodule

// File: source/gshare.sv
`timescale 1ns/10ps

module gshare #(
  parameter int unsigned HLEN = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      flush_i,
  // Fetch side lookup
  input  logic [bpu_pkg::XLEN-1:0]  curr_pc_i,
  // Commit side update
  input  logic                      res_valid_i,
  input  bpu_pkg::resolution_t      res_i,
  output logic                      taken_o
);

  import bpu_pkg::*;

  // Global history, newest outcome in bit 0
  logic [HLEN-1:0] history_q;

  // Table indices for lookup and update
  logic [HLEN-1:0] lookup_idx;
  logic [HLEN-1:0] update_idx;

  // Counters read at each index and the updated value
  sat_cnt_t lookup_cnt;
  sat_cnt_t update_cnt;
  sat_cnt_t next_cnt;

  // PC word bits hashed with history
  assign lookup_idx = curr_pc_i[HLEN+OFFSET-1:OFFSET] ^ history_q;
  assign update_idx = res_i.pc[HLEN+OFFSET-1:OFFSET] ^ history_q;

  // History shifts on every resolution
  // Flush and reset both bring it back to zero
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      history_q <= '0;
    end else if (res_valid_i) begin
      history_q <= {history_q[HLEN-2:0], res_i.taken};
    end
  end

  // Saturating step toward the real outcome
  always_comb begin
    next_cnt = update_cnt;
    if (res_i.taken) begin
      if (update_cnt != SAT_ST) begin
        next_cnt = update_cnt + 2'd1;
      end
    end else begin
      if (update_cnt != SAT_SNT) begin
        next_cnt = update_cnt - 2'd1;
      end
    end
  end

  // Pattern history table seen by fetch
  // Counters survive a flush, so clear stays low
  bpu_table #(
    .DEPTH_BITS (HLEN),
    .entry_t    (sat_cnt_t),
    .RESET_VAL  (SAT_WNT)
  ) u_pht (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .clear_i   (1'b0),
    .rd_idx_i  (lookup_idx),
    .rd_data_o (lookup_cnt),
    .wr_en_i   (res_valid_i),
    .wr_idx_i  (update_idx),
    .wr_data_i (next_cnt)
  );

  // Mirror copy read at the update index
  // Same writes as u_pht, so both always hold equal counters
  bpu_table #(
    .DEPTH_BITS (HLEN),
    .entry_t    (sat_cnt_t),
    .RESET_VAL  (SAT_WNT)
  ) u_pht_mirror (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .clear_i   (1'b0),
    .rd_idx_i  (update_idx),
    .rd_data_o (update_cnt),
    .wr_en_i   (res_valid_i),
    .wr_idx_i  (update_idx),
    .wr_data_i (next_cnt)
  );

  // Counter MSB is the direction guess
  assign taken_o = lookup_cnt[1];

endmodule

// File: source/bpu_table.sv
`timescale 1ns/10ps

module bpu_table #(
  parameter int unsigned DEPTH_BITS = 4,
  parameter type         entry_t    = logic [7:0],
  parameter entry_t      RESET_VAL  = '0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  clear_i,
  // Lookup side
  input  logic [DEPTH_BITS-1:0] rd_idx_i,
  output entry_t                rd_data_o,
  // Update side
  input  logic                  wr_en_i,
  input  logic [DEPTH_BITS-1:0] wr_idx_i,
  input  entry_t                wr_data_i
);

  // Number of entries held
  localparam int unsigned DEPTH = 2 ** DEPTH_BITS;

  // Storage, one payload per index
  entry_t table_q [DEPTH];

  // Reset and clear reload every entry
  // Clear takes priority over a write in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        table_q[i] <= RESET_VAL;
      end
    end else if (wr_en_i) begin
      table_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Read port is purely combinational
  // A write shows up on the read side one cycle later
  assign rd_data_o = table_q[rd_idx_i];

endmodule

// File: source/bpu_pkg.sv
package bpu_pkg;

  // Machine word and address width
  localparam int unsigned XLEN = 32;

  // Instruction alignment bits dropped from every address
  localparam int unsigned OFFSET = 2;

  // 2-bit saturating counter
  // MSB set means predict taken
  typedef logic [1:0] sat_cnt_t;

  // Counter states from strongly not taken up to strongly taken
  localparam sat_cnt_t SAT_SNT = 2'b00;
  localparam sat_cnt_t SAT_WNT = 2'b01;
  localparam sat_cnt_t SAT_ST  = 2'b11;

  // Branch outcome sent back from commit
  typedef struct packed {
    // Address of the resolved branch
    logic [XLEN-1:0] pc;
    // Actual target, meaningful when taken
    logic [XLEN-1:0] target;
    // Real direction of the branch
    logic            taken;
    // Fetch guessed wrong for this branch
    logic            mispredict;
  } resolution_t;

  // Prediction handed to fetch in the lookup cycle
  typedef struct packed {
    // Echo of the looked-up PC
    logic [XLEN-1:0] pc;
    // Predicted direction
    logic            taken;
    // Predicted target, byte address with low bits clear
    logic [XLEN-1:0] target;
  } prediction_t;

endpackage
